//--- src/cdc_message_pkg.sv
package cdc_message_pkg;

  // Payload word and FIFO beat body width
  parameter int WORD_WIDTH = 16;
  // Length field holds length minus one, so 1 to 16 words
  parameter int LENGTH_WIDTH = 4;
  parameter int TAG_WIDTH = 8;
  // Leftover header bits, kept at zero
  parameter int RESERVED_WIDTH = WORD_WIDTH - TAG_WIDTH - LENGTH_WIDTH;

  // Header view of a beat body
  typedef struct packed {
    logic [TAG_WIDTH-1:0]      tag;
    logic [LENGTH_WIDTH-1:0]   length_minus_one;
    logic [RESERVED_WIDTH-1:0] reserved;
  } message_header_t;

  // One word, read as header or as raw payload
  typedef union packed {
    message_header_t       header;
    logic [WORD_WIDTH-1:0] data;
  } beat_body_u;

  // What the FIFO stores
  typedef struct packed {
    logic       is_header;
    beat_body_u body;
  } fifo_beat_t;

  // Request into the framer
  typedef struct packed {
    logic [TAG_WIDTH-1:0]    tag;
    logic [LENGTH_WIDTH-1:0] length_minus_one;
  } message_request_t;

  // Parser output, payload labelled with its message
  typedef struct packed {
    logic [TAG_WIDTH-1:0]  tag;
    logic                  first;
    logic                  last;
    logic [WORD_WIDTH-1:0] data;
  } message_word_t;

endpackage

//--- src/gray_pointer_sync.sv
`timescale 1ns/1ps

module gray_pointer_sync #(
  parameter int WIDTH  = 4,
  parameter int STAGES = 2
) (
  // Destination domain clock and reset
  input  logic             clock,
  input  logic             reset,
  // Gray pointer from the source domain
  input  logic [WIDTH-1:0] gray_in,
  output logic [WIDTH-1:0] gray_out
);

  // Flip-flop chain, stage 0 samples the asynchronous input
  logic [WIDTH-1:0] chain [STAGES];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < STAGES; i++) begin
        chain[i] <= '0;
      end
    end else begin
      // Only one bit moves per pointer step, so a metastable sample
      // settles to either the old or the new pointer
      chain[0] <= gray_in;
      for (int i = 1; i < STAGES; i++) begin
        chain[i] <= chain[i-1];
      end
    end
  end

  // Last stage is safe to use in this domain
  assign gray_out = chain[STAGES-1];

endmodule

//--- src/valid_ready_asynchronous_fifo.sv
`timescale 1ns/1ps

module valid_ready_asynchronous_fifo
  import cdc_message_pkg::*;
#(
  // Power of two, at least 2
  parameter int DEPTH  = 8,
  parameter int STAGES = 2
) (
  // Write side
  input  logic       write_clock,
  input  logic       write_reset,
  input  fifo_beat_t write_data,
  input  logic       write_valid,
  output logic       write_ready,
  // Read side
  input  logic       read_clock,
  input  logic       read_reset,
  output fifo_beat_t read_data,
  output logic       read_valid,
  input  logic       read_ready
);

  // Address bits plus one wrap bit
  localparam int ADDRESS_WIDTH = $clog2(DEPTH);
  localparam int POINTER_WIDTH = ADDRESS_WIDTH + 1;
  // Full when the top two Gray bits differ and the rest match
  localparam logic [POINTER_WIDTH-1:0] FULL_MASK = POINTER_WIDTH'(3) << (POINTER_WIDTH - 2);

  // Storage, written in the write domain, read in the read domain
  fifo_beat_t memory [DEPTH];

  // Write domain pointers
  logic [POINTER_WIDTH-1:0] write_binary;
  logic [POINTER_WIDTH-1:0] write_binary_next;
  logic [POINTER_WIDTH-1:0] write_gray;
  logic [POINTER_WIDTH-1:0] write_gray_next;
  // Read pointer as seen from the write domain
  logic [POINTER_WIDTH-1:0] read_gray_synced;
  logic                     full;
  logic                     write_enable;

  // Read domain pointers
  logic [POINTER_WIDTH-1:0] read_binary;
  logic [POINTER_WIDTH-1:0] read_binary_next;
  logic [POINTER_WIDTH-1:0] read_gray;
  logic [POINTER_WIDTH-1:0] read_gray_next;
  // Write pointer as seen from the read domain
  logic [POINTER_WIDTH-1:0] write_gray_synced;
  logic                     empty;
  logic                     read_enable;

  // Write side

  // Only a handshake moves the pointer
  assign write_enable = write_valid && write_ready;

  assign write_binary_next = write_binary + POINTER_WIDTH'(1);
  assign write_gray_next   = write_binary_next ^ (write_binary_next >> 1);

  always_ff @(posedge write_clock) begin
    if (write_reset) begin
      write_binary <= '0;
      write_gray   <= '0;
    end else if (write_enable) begin
      write_binary <= write_binary_next;
      write_gray   <= write_gray_next;
    end
  end

  // Memory write, low pointer bits address the entry
  always_ff @(posedge write_clock) begin
    if (write_enable) begin
      memory[write_binary[ADDRESS_WIDTH-1:0]] <= write_data;
    end
  end

  // Read pointer into the write domain
  gray_pointer_sync #(
    .WIDTH  (POINTER_WIDTH),
    .STAGES (STAGES)
  ) read_pointer_sync (
    .clock    (write_clock),
    .reset    (write_reset),
    .gray_in  (read_gray),
    .gray_out (read_gray_synced)
  );

  // Pessimistic, a stale read pointer only delays the release
  assign full        = (write_gray == (read_gray_synced ^ FULL_MASK));
  assign write_ready = !full;

  // Read side

  assign read_enable = read_valid && read_ready;

  assign read_binary_next = read_binary + POINTER_WIDTH'(1);
  assign read_gray_next   = read_binary_next ^ (read_binary_next >> 1);

  always_ff @(posedge read_clock) begin
    if (read_reset) begin
      read_binary <= '0;
      read_gray   <= '0;
    end else if (read_enable) begin
      read_binary <= read_binary_next;
      read_gray   <= read_gray_next;
    end
  end

  // Write pointer into the read domain
  gray_pointer_sync #(
    .WIDTH  (POINTER_WIDTH),
    .STAGES (STAGES)
  ) write_pointer_sync (
    .clock    (read_clock),
    .reset    (read_reset),
    .gray_in  (write_gray),
    .gray_out (write_gray_synced)
  );

  // Equal pointers including wrap bit
  assign empty      = (read_gray == write_gray_synced);
  assign read_valid = !empty;

  // Head entry, stable while read_valid waits for read_ready
  assign read_data = memory[read_binary[ADDRESS_WIDTH-1:0]];

endmodule

//--- src/message_framer.sv
`timescale 1ns/1ps

module message_framer
  import cdc_message_pkg::*;
(
  input  logic                  write_clock,
  input  logic                  write_reset,
  // Request channel
  input  message_request_t      request,
  input  logic                  request_valid,
  output logic                  request_ready,
  // Payload channel
  input  logic [WORD_WIDTH-1:0] word_data,
  input  logic                  word_valid,
  output logic                  word_ready,
  // Beats toward the FIFO
  output fifo_beat_t            beat,
  output logic                  beat_valid,
  input  logic                  beat_ready
);

  // FSM states
  localparam logic [1:0] IDLE    = 2'd0;
  localparam logic [1:0] HEADER  = 2'd1;
  localparam logic [1:0] PAYLOAD = 2'd2;

  logic [1:0]              state;
  // Request of the message in flight
  message_request_t        request_q;
  // Payload words left after the current one
  logic [LENGTH_WIDTH-1:0] remaining;

  logic request_transfer;
  logic header_transfer;
  logic word_transfer;

  // Idle only, and held low in reset
  assign request_ready    = (state == IDLE) && !write_reset;
  assign request_transfer = request_valid && request_ready;
  assign header_transfer  = beat_valid && beat_ready && (state == HEADER);
  assign word_transfer    = word_valid && word_ready;

  always_comb begin
    beat       = '0;
    beat_valid = 1'b0;
    word_ready = 1'b0;
    case (state)
      HEADER: begin
        // Header view of the beat body, reserved bits stay zero
        beat.is_header                    = 1'b1;
        beat.body.header.tag              = request_q.tag;
        beat.body.header.length_minus_one = request_q.length_minus_one;
        beat_valid                        = 1'b1;
      end
      PAYLOAD: begin
        // Words pass straight through, ready follows the FIFO
        beat.body.data = word_data;
        beat_valid     = word_valid;
        word_ready     = beat_ready;
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge write_clock) begin
    if (write_reset) begin
      state     <= IDLE;
      request_q <= '0;
      remaining <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (request_transfer) begin
            request_q <= request;
            remaining <= request.length_minus_one;
            state     <= HEADER;
          end
        end
        HEADER: begin
          if (header_transfer) begin
            state <= PAYLOAD;
          end
        end
        PAYLOAD: begin
          if (word_transfer) begin
            // Last word sends the FSM back to idle
            if (remaining == '0) begin
              state <= IDLE;
            end else begin
              remaining <= remaining - LENGTH_WIDTH'(1);
            end
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

endmodule

//--- src/message_parser.sv
`timescale 1ns/1ps

module message_parser
  import cdc_message_pkg::*;
(
  input  logic          read_clock,
  input  logic          read_reset,
  // Beats from the FIFO
  input  fifo_beat_t    beat,
  input  logic          beat_valid,
  output logic          beat_ready,
  // Labelled payload words
  output message_word_t out_word,
  output logic          out_valid,
  input  logic          out_ready
);

  // Context of the message in progress
  logic [TAG_WIDTH-1:0]    tag_q;
  logic [LENGTH_WIDTH-1:0] remaining;
  logic                    first_q;

  logic header_transfer;
  logic payload_transfer;

  // Headers are swallowed at once, payload waits on out_ready
  assign beat_ready = out_ready || (beat_valid && beat.is_header);

  assign header_transfer  = beat_valid && beat_ready && beat.is_header;
  assign payload_transfer = out_valid && out_ready;

  // Header never reaches the output
  assign out_valid = beat_valid && !beat.is_header;

  // Payload view of the same word
  assign out_word.tag   = tag_q;
  assign out_word.first = first_q;
  assign out_word.last  = (remaining == '0);
  assign out_word.data  = beat.body.data;

  // Tag latched from each header
  always_ff @(posedge read_clock) begin
    if (header_transfer) begin
      tag_q <= beat.body.header.tag;
    end
  end

  always_ff @(posedge read_clock) begin
    if (read_reset) begin
      remaining <= '0;
      first_q   <= 1'b0;
    end else if (header_transfer) begin
      // Header view gives the word count
      remaining <= beat.body.header.length_minus_one;
      first_q   <= 1'b1;
    end else if (payload_transfer) begin
      first_q <= 1'b0;
      // Hold at zero after the last word
      if (remaining != '0) begin
        remaining <= remaining - LENGTH_WIDTH'(1);
      end
    end
  end

endmodule

//--- src/cdc_message_top.sv
`timescale 1ns/1ps

module cdc_message_top
  import cdc_message_pkg::*;
#(
  parameter int DEPTH  = 8,
  parameter int STAGES = 2
) (
  // Write domain
  input  logic                  write_clock,
  input  logic                  write_reset,
  input  message_request_t      request,
  input  logic                  request_valid,
  output logic                  request_ready,
  input  logic [WORD_WIDTH-1:0] word_data,
  input  logic                  word_valid,
  output logic                  word_ready,
  // Read domain
  input  logic                  read_clock,
  input  logic                  read_reset,
  output message_word_t         out_word,
  output logic                  out_valid,
  input  logic                  out_ready
);

  // Framer to FIFO, write domain
  fifo_beat_t write_beat;
  logic       write_valid;
  logic       write_ready;

  // FIFO to parser, read domain
  fifo_beat_t read_beat;
  logic       read_valid;
  logic       read_ready;

  message_framer framer (
    .write_clock   (write_clock),
    .write_reset   (write_reset),
    .request       (request),
    .request_valid (request_valid),
    .request_ready (request_ready),
    .word_data     (word_data),
    .word_valid    (word_valid),
    .word_ready    (word_ready),
    .beat          (write_beat),
    .beat_valid    (write_valid),
    .beat_ready    (write_ready)
  );

  // Clock crossing
  valid_ready_asynchronous_fifo #(
    .DEPTH  (DEPTH),
    .STAGES (STAGES)
  ) fifo (
    .write_clock (write_clock),
    .write_reset (write_reset),
    .write_data  (write_beat),
    .write_valid (write_valid),
    .write_ready (write_ready),
    .read_clock  (read_clock),
    .read_reset  (read_reset),
    .read_data   (read_beat),
    .read_valid  (read_valid),
    .read_ready  (read_ready)
  );

  message_parser parser (
    .read_clock (read_clock),
    .read_reset (read_reset),
    .beat       (read_beat),
    .beat_valid (read_valid),
    .beat_ready (read_ready),
    .out_word   (out_word),
    .out_valid  (out_valid),
    .out_ready  (out_ready)
  );

endmodule

//--- testbench/cdc_message_chk.sv
`timescale 1ns/1ps

module cdc_message_chk #(
  parameter int POINTER_WIDTH = 4
) (
  input logic                     write_clock,
  input logic                     write_reset,
  input logic                     read_clock,
  input logic                     read_reset,
  input logic                     full,
  input logic                     empty,
  input logic                     read_valid,
  input logic [POINTER_WIDTH-1:0] write_binary,
  input logic [POINTER_WIDTH-1:0] write_gray,
  input logic [POINTER_WIDTH-1:0] read_binary,
  input logic [POINTER_WIDTH-1:0] read_gray_synced
);

  // Read by the testbench at the end
  int failure_count = 0;

  // No write lands on a full FIFO
  no_write_when_full: assert property (
    @(posedge write_clock) disable iff (write_reset) full |=> $stable(write_binary)
  ) else begin
    failure_count++;
    $error("write pointer moved while full");
  end

  // No read from an empty FIFO
  no_read_when_empty: assert property (
    @(posedge read_clock) disable iff (read_reset) empty |=> $stable(read_binary)
  ) else begin
    failure_count++;
    $error("read pointer moved while empty");
  end

  // Slow read pointer sampled by the faster write clock, one bit per step
  read_sync_one_bit: assert property (
    @(posedge write_clock) disable iff (write_reset)
      $countones(read_gray_synced ^ $past(read_gray_synced)) <= 1
  ) else begin
    failure_count++;
    $error("synchronized read pointer changed by more than one bit");
  end

  // Write pointer can step twice per read cycle, so check it at its source
  write_gray_one_bit: assert property (
    @(posedge write_clock) disable iff (write_reset)
      $countones(write_gray ^ $past(write_gray)) <= 1
  ) else begin
    failure_count++;
    $error("write Gray pointer changed by more than one bit");
  end

  read_valid_low_in_reset: assert property (
    @(posedge read_clock) read_reset |=> !read_valid
  ) else begin
    failure_count++;
    $error("read_valid high after a read reset edge");
  end

endmodule

bind valid_ready_asynchronous_fifo cdc_message_chk #(
  .POINTER_WIDTH (POINTER_WIDTH)
) fifo_checks (
  .write_clock      (write_clock),
  .write_reset      (write_reset),
  .read_clock       (read_clock),
  .read_reset       (read_reset),
  .full             (full),
  .empty            (empty),
  .read_valid       (read_valid),
  .write_binary     (write_binary),
  .write_gray       (write_gray),
  .read_binary      (read_binary),
  .read_gray_synced (read_gray_synced)
);

//--- testbench/cdc_message_tb.sv
`timescale 1ns/1ps

module cdc_message_tb
  import cdc_message_pkg::*;
;

  localparam int NUM_MESSAGES = 40;
  // Messages in this range go back to back with word_valid held high
  localparam int BURST_FIRST  = 20;
  localparam int BURST_LAST   = 29;
  // Read cycles without out_valid after the last input word
  localparam int DRAIN_IDLE_CYCLES = 16;

  // Clocks and resets
  logic write_clock = 1'b0;
  logic read_clock  = 1'b0;
  logic write_reset = 1'b1;
  logic read_reset  = 1'b1;

  // DUT ports
  message_request_t      request;
  logic                  request_valid;
  logic                  request_ready;
  logic [WORD_WIDTH-1:0] word_data;
  logic                  word_valid;
  logic                  word_ready;
  message_word_t         out_word;
  logic                  out_valid;
  logic                  out_ready;

  // Reference model, one entry per payload word accepted at the input
  message_word_t expected_words[$];
  int            length_plan [NUM_MESSAGES];
  int            sent_count     = 0;
  int            received_count = 0;

  // Drain tracking across the two domains
  bit sending_done     = 1'b0;
  int idle_read_cycles = 0;

  // Watchdog
  int cycle_count   = 0;
  int timeout_limit = 0;

  logic [31:0] lcg_state = 32'h1f1cb3c6;

  cdc_message_top #(
    .DEPTH  (8),
    .STAGES (2)
  ) DUT (
    .write_clock   (write_clock),
    .write_reset   (write_reset),
    .request       (request),
    .request_valid (request_valid),
    .request_ready (request_ready),
    .word_data     (word_data),
    .word_valid    (word_valid),
    .word_ready    (word_ready),
    .read_clock    (read_clock),
    .read_reset    (read_reset),
    .out_word      (out_word),
    .out_valid     (out_valid),
    .out_ready     (out_ready)
  );

  // 4 ns write clock, 7 ns read clock, edges never coincide
  always #2 write_clock = ~write_clock;
  always #3.5 read_clock = ~read_clock;

  // LCG step, upper bits reduced to 0 .. limit-1
  function automatic int rand_below(int limit);
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return int'(lcg_state >> 8) % limit;
  endfunction

  task automatic report_failure(input string reason);
    $display("%s", reason);
    $display(">>> FAIL");
    $fatal(1, "testbench stopped on first error");
  endtask

  task automatic check_word(input message_word_t actual, input message_word_t expected);
    if (actual !== expected) begin
      $display("Fail out_word: got %h (tag %h first %h last %h data %h), expected %h",
               actual, actual.tag, actual.first, actual.last, actual.data, expected);
      report_failure("output word mismatch");
    end
  endtask

  task automatic check_count(input string name, input int actual, input int expected);
    if (actual != expected) begin
      $display("Fail %s: got %h, expected %h", name, actual, expected);
      report_failure("word count mismatch");
    end
  endtask

  // One request, then its payload words, model updated per transfer
  task automatic send_message(input int index, input bit burst);
    message_request_t req;
    message_word_t    expected;
    int               gap;
    req.tag              = TAG_WIDTH'(rand_below(256));
    req.length_minus_one = LENGTH_WIDTH'(length_plan[index]);
    request       <= req;
    request_valid <= 1'b1;
    do @(posedge write_clock); while (!request_ready);
    request_valid <= 1'b0;
    for (int i = 0; i <= length_plan[index]; i++) begin
      // Random idle gaps outside the burst range
      gap = burst ? 0 : ((rand_below(3) == 0) ? 1 + rand_below(4) : 0);
      if (gap > 0) begin
        word_valid <= 1'b0;
        repeat (gap) @(posedge write_clock);
      end
      expected.tag   = req.tag;
      expected.first = (i == 0);
      expected.last  = (i == length_plan[index]);
      expected.data  = WORD_WIDTH'(rand_below(65536));
      word_data  <= expected.data;
      word_valid <= 1'b1;
      do @(posedge write_clock); while (!word_ready);
      expected_words.push_back(expected);
      sent_count++;
    end
    word_valid <= 1'b0;
  endtask

  // Write domain, reset then all messages
  initial begin : write_stimulus
    int total_words;
    int failures;
    request       = '0;
    request_valid = 1'b0;
    word_data     = '0;
    word_valid    = 1'b0;
    total_words   = 0;
    // Lengths fixed up front, 1 and 16 always present
    for (int m = 0; m < NUM_MESSAGES; m++) begin
      if (m == 0) begin
        length_plan[m] = 0;
      end else if (m == 1) begin
        length_plan[m] = 15;
      end else if (m >= BURST_FIRST && m <= BURST_LAST && m % 3 != 2) begin
        length_plan[m] = (m % 3 == 0) ? 0 : 15;
      end else begin
        length_plan[m] = rand_below(16);
      end
      total_words += length_plan[m] + 1;
    end
    timeout_limit = 40 * total_words + 200;
    repeat (2) @(posedge write_clock);
    write_reset <= 1'b0;
    // Quiet window, out_valid must stay low
    repeat (20) @(posedge write_clock);
    for (int m = 0; m < NUM_MESSAGES; m++) begin
      send_message(m, m >= BURST_FIRST && m <= BURST_LAST);
    end
    // Drain until the output stays idle after the last word
    sending_done = 1'b1;
    while (idle_read_cycles < DRAIN_IDLE_CYCLES) @(posedge write_clock);
    check_count("received_count", received_count, sent_count);
    failures = DUT.fifo.fifo_checks.failure_count;
    if (failures == 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      $display("%0d FIFO assertion failures were seen", failures);
      $display(">>> FAIL");
      $fatal(1, "assertion failures");
    end
  end

  // Read domain, output checks and random back-pressure
  initial begin : read_stimulus
    int stall_left;
    stall_left = 0;
    out_ready  = 1'b0;
    repeat (2) @(posedge read_clock);
    read_reset <= 1'b0;
    forever begin
      @(posedge read_clock);
      // Any valid word must already be in the model
      if (out_valid && expected_words.size() == 0) begin
        report_failure("out_valid went high with no payload word outstanding");
      end
      if (out_valid && out_ready) begin
        check_word(out_word, expected_words.pop_front());
        received_count++;
      end
      // Idle run counted only once all words are in
      if (!sending_done || out_valid) begin
        idle_read_cycles = 0;
      end else begin
        idle_read_cycles++;
      end
      // Long stalls fill the FIFO and stall the framer
      if (stall_left > 0) begin
        stall_left--;
        out_ready <= 1'b0;
      end else if (rand_below(24) == 0) begin
        stall_left = 20 + rand_below(40);
        out_ready <= 1'b0;
      end else begin
        out_ready <= (rand_below(4) != 0);
      end
    end
  end

  // Limit scales with the planned word count
  always @(posedge write_clock) begin
    cycle_count <= cycle_count + 1;
    if (timeout_limit > 0 && cycle_count > timeout_limit) begin
      report_failure($sformatf("Timeout after %0d write clock cycles, %0d of %0d words received",
                               cycle_count, received_count, sent_count));
    end
  end

endmodule

//--- flist.f
src/cdc_message_pkg.sv
src/gray_pointer_sync.sv
src/valid_ready_asynchronous_fifo.sv
src/message_framer.sv
src/message_parser.sv
src/cdc_message_top.sv
testbench/cdc_message_chk.sv
testbench/cdc_message_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = cdc_message_tb
FILELIST = flist.f
BUILD    = obj_dir
PASS_MSG = >>> PASS

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD)
